// File: files.f
rtl/rx_frame_pkg.sv
rtl/ht_sig_crc8.sv
rtl/fcs_crc32.sv
rtl/sig_field_decoder.sv
rtl/rx_frame_ctrl.sv
rtl/rx_frame_top.sv
tests/rx_frame_tb.sv

// File: rtl/fcs_crc32.sv
`timescale 1ns/1ps

module fcs_crc32 (
    input  logic       clock,
    input  logic       equalizer_reset,
    input  logic       clear_i,
    input  logic [7:0] byte_i,
    input  logic       byte_valid_i,
    output logic       fcs_good_o
);
    import rx_frame_pkg::*;

    logic [31:0] crc_reg;
    logic [31:0] crc_base;
    logic [7:0]  byte_rev;

    // msb first shift of one byte
    function automatic logic [31:0] crc32_byte(input logic [31:0] c, input logic [7:0] d);
        logic [31:0] r;
        r = c;
        for (int i = 7; i >= 0; i--) begin
            if (r[31] ^ d[i]) begin
                r = {r[30:0], 1'b0} ^ CRC32_POLY;
            end else begin
                r = {r[30:0], 1'b0};
            end
        end
        return r;
    endfunction

    // bytes arrive lsb first on air
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            byte_rev[i] = byte_i[7-i];
        end
    end

    // a byte on the clear cycle starts from the seed
    assign crc_base = clear_i ? 32'hffff_ffff : crc_reg;

    always_ff @(posedge clock) begin
        if (equalizer_reset) begin
            crc_reg <= 32'hffff_ffff;
        end else if (byte_valid_i) begin
            crc_reg <= crc32_byte(crc_base, byte_rev);
        end else if (clear_i) begin
            crc_reg <= 32'hffff_ffff;
        end
    end

    assign fcs_good_o = (crc_reg == FCS_RESIDUE);

endmodule

// File: rtl/ht_sig_crc8.sv
`timescale 1ns/1ps

module ht_sig_crc8 (
    input  logic                                clock,
    input  logic                                equalizer_reset,
    input  logic                                crc_start_i,
    input  logic [rx_frame_pkg::SIG_WORD_W-1:0] ht_sig1_word_i,
    input  logic [rx_frame_pkg::SIG_WORD_W-1:0] ht_sig2_word_i,
    output logic [7:0]                          crc_o,
    output logic                                crc_done_o
);
    import rx_frame_pkg::*;

    localparam int CNT_W = $clog2(HT_CRC_BITS);

    logic [CNT_W-1:0]       bit_cnt;
    logic                   running;
    logic [7:0]             crc_reg;
    logic [HT_CRC_BITS-1:0] covered;

    // x^8 + x^2 + x + 1, one bit per call
    function automatic logic [7:0] crc8_step(input logic [7:0] c, input logic b);
        logic fb;
        fb = b ^ c[7];
        return {c[6:2], c[1] ^ fb, c[0] ^ fb, fb};
    endfunction

    assign covered = {ht_sig2_word_i[HT_CRC_BITS-SIG_WORD_W-1:0], ht_sig1_word_i};

    // c7 sits in field bit 0, inverted
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            crc_o[i] = ~crc_reg[7-i];
        end
    end

    // bit 0 goes in on the start edge itself
    always_ff @(posedge clock) begin
        if (crc_start_i) begin
            crc_reg <= crc8_step(8'hff, covered[0]);
        end else if (running) begin
            crc_reg <= crc8_step(crc_reg, covered[bit_cnt]);
        end
    end

    always_ff @(posedge clock) begin
        if (equalizer_reset) begin
            bit_cnt <= '0;
            running <= 1'b0;
            crc_done_o <= 1'b0;
        end else begin
            crc_done_o <= 1'b0;
            if (crc_start_i) begin
                bit_cnt <= CNT_W'(1);
                running <= 1'b1;
            end else if (running) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == CNT_W'(HT_CRC_BITS - 1)) begin
                    running <= 1'b0;
                    crc_done_o <= 1'b1;
                end
            end
        end
    end

    // controller waits for done before it starts again
    assert property (@(posedge clock) disable iff (equalizer_reset)
        crc_start_i |-> !running);

endmodule

// File: rtl/rx_frame_ctrl.sv
`timescale 1ns/1ps

module rx_frame_ctrl #(
    parameter bit HT_ENABLE = 1'b1
) (
    input  logic                                clock,
    input  logic                                equalizer_reset,
    input  logic                                frame_start_i,
    input  logic [7:0]                          byte_i,
    input  logic                                byte_valid_i,
    input  logic                                ht_det_valid_i,
    input  logic                                ht_det_i,
    input  rx_frame_pkg::rx_status_e            legacy_status_i,
    input  rx_frame_pkg::rx_status_e            ht_status_i,
    input  logic [3:0]                          legacy_rate_i,
    input  logic [rx_frame_pkg::LEN_W-1:0]      legacy_len_i,
    input  logic [rx_frame_pkg::RATE_W-2:0]     ht_mcs_i,
    input  logic [rx_frame_pkg::LEN_W-1:0]      ht_len_i,
    input  logic                                crc_done_i,
    input  logic                                fcs_good_i,
    output logic [rx_frame_pkg::SIG_WORD_W-1:0] signal_word_o,
    output logic [rx_frame_pkg::SIG_WORD_W-1:0] ht_sig1_word_o,
    output logic [rx_frame_pkg::SIG_WORD_W-1:0] ht_sig2_word_o,
    output logic                                crc_start_o,
    output logic                                fcs_clear_o,
    output logic                                data_byte_valid_o,
    output logic                                busy_o,
    output logic                                header_strobe_o,
    output logic                                header_valid_o,
    output logic                                pkt_ht_o,
    output logic [rx_frame_pkg::RATE_W-1:0]     pkt_rate_o,
    output logic [rx_frame_pkg::LEN_W-1:0]      pkt_len_o,
    output logic                                ht_sig_strobe_o,
    output logic                                ht_sig_crc_ok_o,
    output rx_frame_pkg::rx_status_e            status_o,
    output logic [7:0]                          data_o,
    output logic                                data_valid_o,
    output logic [rx_frame_pkg::LEN_W-1:0]      byte_count_o,
    output logic                                fcs_valid_o,
    output logic                                fcs_ok_o
);
    import rx_frame_pkg::*;

    rx_state_e        state;
    logic [LEN_W-1:0] byte_cnt;

    assign busy_o = (state != idle);
    assign byte_count_o = byte_cnt;
    // bytes past the length are dropped
    assign data_byte_valid_o = byte_valid_i && (state == decode_data) && (byte_cnt != pkt_len_o);

    ////////////////////////////////////////////////////////////////////////////
    // header assembly, bytes enter from the top
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (byte_valid_i && state == decode_signal) begin
            signal_word_o <= {byte_i, signal_word_o[SIG_WORD_W-1:8]};
        end
        if (byte_valid_i && state == ht_signal) begin
            // first three bytes are HT-SIG1
            if (byte_cnt < 3) begin
                ht_sig1_word_o <= {byte_i, ht_sig1_word_o[SIG_WORD_W-1:8]};
            end else begin
                ht_sig2_word_o <= {byte_i, ht_sig2_word_o[SIG_WORD_W-1:8]};
            end
        end
        if (data_byte_valid_o) begin
            data_o <= byte_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // framing FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (equalizer_reset) begin
            state <= idle;
            byte_cnt <= '0;
            status_o <= ok;
            header_strobe_o <= 1'b0;
            header_valid_o <= 1'b0;
            pkt_ht_o <= 1'b0;
            pkt_rate_o <= '0;
            pkt_len_o <= '0;
            ht_sig_strobe_o <= 1'b0;
            ht_sig_crc_ok_o <= 1'b0;
            crc_start_o <= 1'b0;
            fcs_clear_o <= 1'b0;
            fcs_valid_o <= 1'b0;
            fcs_ok_o <= 1'b0;
            data_valid_o <= 1'b0;
        end else begin
            // single-cycle strobes
            header_strobe_o <= 1'b0;
            ht_sig_strobe_o <= 1'b0;
            crc_start_o <= 1'b0;
            fcs_clear_o <= 1'b0;
            fcs_valid_o <= 1'b0;
            data_valid_o <= data_byte_valid_o;

            case (state)
                idle: begin
                    if (frame_start_i) begin
                        byte_cnt <= '0;
                        header_valid_o <= 1'b0;
                        pkt_ht_o <= 1'b0;
                        ht_sig_crc_ok_o <= 1'b0;
                        fcs_ok_o <= 1'b0;
                        state <= decode_signal;
                    end
                end

                decode_signal: begin
                    if (byte_valid_i) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == 2) begin
                            state <= check_signal;
                        end
                    end
                end

                check_signal: begin
                    pkt_rate_o <= RATE_W'(legacy_rate_i);
                    pkt_len_o <= legacy_len_i;
                    status_o <= legacy_status_i;
                    if (legacy_status_i != ok) begin
                        header_strobe_o <= 1'b1;
                        state <= frame_error;
                    end else if (HT_ENABLE && legacy_rate_i == LEGACY_BASE_RATE) begin
                        state <= detect_ht;
                    end else begin
                        header_strobe_o <= 1'b1;
                        header_valid_o <= 1'b1;
                        fcs_clear_o <= 1'b1;
                        byte_cnt <= '0;
                        state <= decode_data;
                    end
                end

                // verdict comes from the equalizer side
                detect_ht: begin
                    if (ht_det_valid_i && ht_det_i) begin
                        byte_cnt <= '0;
                        state <= ht_signal;
                    end else if (ht_det_valid_i) begin
                        header_strobe_o <= 1'b1;
                        header_valid_o <= 1'b1;
                        fcs_clear_o <= 1'b1;
                        byte_cnt <= '0;
                        state <= decode_data;
                    end
                end

                ht_signal: begin
                    if (byte_valid_i) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == 5) begin
                            crc_start_o <= 1'b1;
                            state <= check_ht_crc;
                        end
                    end
                end

                check_ht_crc: begin
                    if (crc_done_i) begin
                        ht_sig_strobe_o <= 1'b1;
                        pkt_ht_o <= 1'b1;
                        pkt_rate_o <= {1'b1, ht_mcs_i};
                        pkt_len_o <= ht_len_i;
                        if (ht_status_i == wrong_crc) begin
                            header_strobe_o <= 1'b1;
                            status_o <= wrong_crc;
                            state <= frame_error;
                        end else begin
                            ht_sig_crc_ok_o <= 1'b1;
                            state <= check_ht_sig;
                        end
                    end
                end

                check_ht_sig: begin
                    header_strobe_o <= 1'b1;
                    status_o <= ht_status_i;
                    if (ht_status_i != ok) begin
                        state <= frame_error;
                    end else begin
                        header_valid_o <= 1'b1;
                        fcs_clear_o <= 1'b1;
                        byte_cnt <= '0;
                        state <= decode_data;
                    end
                end

                // ends on the length count
                decode_data: begin
                    if (data_byte_valid_o) begin
                        byte_cnt <= byte_cnt + 1'b1;
                    end else if (byte_cnt == pkt_len_o) begin
                        fcs_valid_o <= 1'b1;
                        fcs_ok_o <= fcs_good_i;
                        status_o <= fcs_good_i ? ok : wrong_fcs;
                        state <= decode_done;
                    end
                end

                frame_error: begin
                    state <= idle;
                end

                decode_done: begin
                    state <= idle;
                end

                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // strobes never stretch over two cycles
    assert property (@(posedge clock) disable iff (equalizer_reset)
        header_strobe_o |=> !header_strobe_o);
    assert property (@(posedge clock) disable iff (equalizer_reset)
        fcs_valid_o |=> !fcs_valid_o);

    // forwarded bytes belong to the data phase only
    assert property (@(posedge clock) disable iff (equalizer_reset)
        data_valid_o |-> state == decode_data);

endmodule

// File: rtl/rx_frame_pkg.sv
package rx_frame_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // controller states and result codes
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [4:0] {
        idle,
        decode_signal,
        check_signal,
        detect_ht,
        ht_signal,
        check_ht_crc,
        check_ht_sig,
        decode_data,
        frame_error,
        decode_done
    } rx_state_e;

    // order matters, the testbench compares against these codes
    typedef enum logic [4:0] {
        ok,
        parity_fail,
        wrong_rsvd,
        wrong_tail,
        unsupported_rate,
        wrong_crc,
        unsupported_mcs,
        unsupported_cbw,
        ht_wrong_rsvd,
        unsupported_stbc,
        unsupported_fec,
        unsupported_spatial,
        ht_wrong_tail,
        unsupported_aggr,
        wrong_fcs
    } rx_status_e;

    ////////////////////////////////////////////////////////////////////////////
    // field widths and header rules
    ////////////////////////////////////////////////////////////////////////////

    localparam int SIG_WORD_W = 24;
    localparam int LEN_W = 16;
    // top bit flags HT, low bits hold rate code or MCS
    localparam int RATE_W = 8;

    // 6 Mbps, the only legacy rate that can hide an HT-SIG
    localparam logic [3:0] LEGACY_BASE_RATE = 4'b1011;
    localparam int HT_MAX_MCS = 7;

    ////////////////////////////////////////////////////////////////////////////
    // CRC constants
    ////////////////////////////////////////////////////////////////////////////

    // all of HT-SIG1 plus the low 10 bits of HT-SIG2
    localparam int HT_CRC_BITS = 34;
    localparam logic [31:0] CRC32_POLY = 32'h04c1_1db7;
    // register value after a good frame including its FCS
    localparam logic [31:0] FCS_RESIDUE = 32'hc704_dd7b;

endpackage

// File: rtl/rx_frame_top.sv
`timescale 1ns/1ps

module rx_frame_top #(
    parameter bit HT_ENABLE = 1'b1
) (
    input  logic                              clock,
    input  logic                              equalizer_reset,
    input  logic                              frame_start_i,
    input  logic [7:0]                        byte_i,
    input  logic                              byte_valid_i,
    input  logic                              ht_det_valid_i,
    input  logic                              ht_det_i,
    output logic                              busy_o,
    output logic                              header_strobe_o,
    output logic                              header_valid_o,
    output logic                              pkt_ht_o,
    output logic [rx_frame_pkg::RATE_W-1:0]   pkt_rate_o,
    output logic [rx_frame_pkg::LEN_W-1:0]    pkt_len_o,
    output logic                              ht_sig_strobe_o,
    output logic                              ht_sig_crc_ok_o,
    output rx_frame_pkg::rx_status_e          status_o,
    output logic [7:0]                        data_o,
    output logic                              data_valid_o,
    output logic [rx_frame_pkg::LEN_W-1:0]    byte_count_o,
    output logic                              fcs_valid_o,
    output logic                              fcs_ok_o
);
    import rx_frame_pkg::*;

    // header words from the controller
    logic [SIG_WORD_W-1:0] signal_word;
    logic [SIG_WORD_W-1:0] ht_sig1_word;
    logic [SIG_WORD_W-1:0] ht_sig2_word;

    // decoded fields
    logic [3:0]        legacy_rate;
    logic [LEN_W-1:0]  legacy_len;
    logic [RATE_W-2:0] ht_mcs;
    logic [LEN_W-1:0]  ht_len;
    rx_status_e        legacy_status;
    rx_status_e        ht_status;

    // crc handshakes
    logic       crc_start;
    logic       crc_done;
    logic [7:0] ht_crc;
    logic       fcs_clear;
    logic       data_byte_valid;
    logic       fcs_good;

    rx_frame_ctrl #(
        .HT_ENABLE(HT_ENABLE)
    ) ctrl_i (
        .clock(clock),
        .equalizer_reset(equalizer_reset),
        .frame_start_i(frame_start_i),
        .byte_i(byte_i),
        .byte_valid_i(byte_valid_i),
        .ht_det_valid_i(ht_det_valid_i),
        .ht_det_i(ht_det_i),
        .legacy_status_i(legacy_status),
        .ht_status_i(ht_status),
        .legacy_rate_i(legacy_rate),
        .legacy_len_i(legacy_len),
        .ht_mcs_i(ht_mcs),
        .ht_len_i(ht_len),
        .crc_done_i(crc_done),
        .fcs_good_i(fcs_good),
        .signal_word_o(signal_word),
        .ht_sig1_word_o(ht_sig1_word),
        .ht_sig2_word_o(ht_sig2_word),
        .crc_start_o(crc_start),
        .fcs_clear_o(fcs_clear),
        .data_byte_valid_o(data_byte_valid),
        .busy_o(busy_o),
        .header_strobe_o(header_strobe_o),
        .header_valid_o(header_valid_o),
        .pkt_ht_o(pkt_ht_o),
        .pkt_rate_o(pkt_rate_o),
        .pkt_len_o(pkt_len_o),
        .ht_sig_strobe_o(ht_sig_strobe_o),
        .ht_sig_crc_ok_o(ht_sig_crc_ok_o),
        .status_o(status_o),
        .data_o(data_o),
        .data_valid_o(data_valid_o),
        .byte_count_o(byte_count_o),
        .fcs_valid_o(fcs_valid_o),
        .fcs_ok_o(fcs_ok_o)
    );

    sig_field_decoder decoder_i (
        .signal_word_i(signal_word),
        .ht_sig1_word_i(ht_sig1_word),
        .ht_sig2_word_i(ht_sig2_word),
        .crc_i(ht_crc),
        .legacy_rate_o(legacy_rate),
        .legacy_len_o(legacy_len),
        .ht_mcs_o(ht_mcs),
        .ht_len_o(ht_len),
        .legacy_status_o(legacy_status),
        .ht_status_o(ht_status)
    );

    ht_sig_crc8 crc8_i (
        .clock(clock),
        .equalizer_reset(equalizer_reset),
        .crc_start_i(crc_start),
        .ht_sig1_word_i(ht_sig1_word),
        .ht_sig2_word_i(ht_sig2_word),
        .crc_o(ht_crc),
        .crc_done_o(crc_done)
    );

    fcs_crc32 fcs_i (
        .clock(clock),
        .equalizer_reset(equalizer_reset),
        .clear_i(fcs_clear),
        .byte_i(byte_i),
        .byte_valid_i(data_byte_valid),
        .fcs_good_o(fcs_good)
    );

endmodule

// File: rtl/sig_field_decoder.sv
`timescale 1ns/1ps

module sig_field_decoder (
    input  logic [rx_frame_pkg::SIG_WORD_W-1:0] signal_word_i,
    input  logic [rx_frame_pkg::SIG_WORD_W-1:0] ht_sig1_word_i,
    input  logic [rx_frame_pkg::SIG_WORD_W-1:0] ht_sig2_word_i,
    input  logic [7:0]                          crc_i,
    output logic [3:0]                          legacy_rate_o,
    output logic [rx_frame_pkg::LEN_W-1:0]      legacy_len_o,
    output logic [rx_frame_pkg::RATE_W-2:0]     ht_mcs_o,
    output logic [rx_frame_pkg::LEN_W-1:0]      ht_len_o,
    output rx_frame_pkg::rx_status_e            legacy_status_o,
    output rx_frame_pkg::rx_status_e            ht_status_o
);
    import rx_frame_pkg::*;

    logic       legacy_rsvd;
    logic       legacy_parity_ok;
    logic [5:0] legacy_tail;
    logic       ht_cbw;
    logic       ht_rsvd;
    logic       ht_aggr;
    logic [1:0] ht_stbc;
    logic       ht_fec;
    logic [1:0] ht_num_ext;
    logic [7:0] ht_crc;
    logic [5:0] ht_tail;

    // legacy SIGNAL
    assign legacy_rate_o = signal_word_i[3:0];
    assign legacy_rsvd = signal_word_i[4];
    assign legacy_len_o = LEN_W'(signal_word_i[16:5]);
    // even parity over rate, reserved, length and parity bit
    assign legacy_parity_ok = ~^signal_word_i[17:0];
    assign legacy_tail = signal_word_i[23:18];

    // HT-SIG1
    assign ht_mcs_o = ht_sig1_word_i[6:0];
    assign ht_cbw = ht_sig1_word_i[7];
    assign ht_len_o = ht_sig1_word_i[23:8];

    // HT-SIG2, smoothing, sounding and short GI are not checked
    assign ht_rsvd = ht_sig2_word_i[2];
    assign ht_aggr = ht_sig2_word_i[3];
    assign ht_stbc = ht_sig2_word_i[5:4];
    assign ht_fec = ht_sig2_word_i[6];
    assign ht_num_ext = ht_sig2_word_i[9:8];
    assign ht_crc = ht_sig2_word_i[17:10];
    assign ht_tail = ht_sig2_word_i[23:18];

    // first failing check wins
    always_comb begin
        if (!legacy_parity_ok) legacy_status_o = parity_fail;
        else if (legacy_rsvd) legacy_status_o = wrong_rsvd;
        else if (legacy_tail != '0) legacy_status_o = wrong_tail;
        else if (!legacy_rate_o[3]) legacy_status_o = unsupported_rate;
        else legacy_status_o = ok;
    end

    always_comb begin
        if (crc_i != ht_crc) ht_status_o = wrong_crc;
        else if (ht_mcs_o > HT_MAX_MCS) ht_status_o = unsupported_mcs;
        else if (ht_cbw) ht_status_o = unsupported_cbw;
        else if (!ht_rsvd) ht_status_o = ht_wrong_rsvd;
        else if (ht_stbc != '0) ht_status_o = unsupported_stbc;
        else if (ht_fec) ht_status_o = unsupported_fec;
        else if (ht_num_ext != '0) ht_status_o = unsupported_spatial;
        else if (ht_tail != '0) ht_status_o = ht_wrong_tail;
        // no A-MPDU delimiter parsing
        else if (ht_aggr) ht_status_o = unsupported_aggr;
        else ht_status_o = ok;
    end

endmodule

// File: tests/rx_frame_patterns.hex
// header: [31:20] byte count, [19:16] HT verdict (0 none, 1 legacy, 2 HT),
// [15:12] header valid, [11:8] fcs_ok, [7:0] status code; then the bytes
// legacy 24 Mbps, payload "123456789" with its FCS
01001100 a9 01 02 31 32 33 34 35 36 37 38 39 26 39 f4 cb
// same frame, one payload byte flipped
0100100e a9 01 02 31 32 33 34 34 36 37 38 39 26 39 f4 cb
// parity broken
00300001 a9 01 00
01001100 a9 01 02 31 32 33 34 35 36 37 38 39 26 39 f4 cb
// reserved bit set, tail bad too
00300002 b9 01 04
// tail not zero
00300003 a9 01 12
// rate code without the top bit
00300004 a5 01 02
// 6 Mbps, negative HT verdict
01011100 ab 01 00 31 32 33 34 35 36 37 38 39 26 39 f4 cb
// 6 Mbps, HT MCS 3
01621100 ab 01 00 03 0d 00 07 00 03 31 32 33 34 35 36 37 38 39 26 39 f4 cb
// HT-SIG CRC field corrupted
00920005 ab 01 00 03 0d 00 07 04 03
01621100 ab 01 00 03 0d 00 07 00 03 31 32 33 34 35 36 37 38 39 26 39 f4 cb
// MCS 9, then 40 MHz, then aggregation
00920006 ab 01 00 09 0d 00 07 7c 01
00920007 ab 01 00 83 0d 00 07 68 03
0092000d ab 01 00 03 0d 00 0f 8c 00
01001100 a9 01 02 31 32 33 34 35 36 37 38 39 26 39 f4 cb
00000000

// File: tests/rx_frame_tb.sv
`timescale 1ns/1ps

module rx_frame_tb;
    import rx_frame_pkg::*;

    localparam int MEM_DEPTH = 256;
    localparam int RECORD_CYCLES = 60;

    logic                clock;
    logic                equalizer_reset;
    logic                frame_start_i;
    logic [7:0]          byte_i;
    logic                byte_valid_i;
    logic                ht_det_valid_i;
    logic                ht_det_i;

    logic                busy_o;
    logic                header_strobe_o;
    logic                header_valid_o;
    logic                pkt_ht_o;
    logic [RATE_W-1:0]   pkt_rate_o;
    logic [LEN_W-1:0]    pkt_len_o;
    logic                ht_sig_strobe_o;
    logic                ht_sig_crc_ok_o;
    rx_status_e          status_o;
    logic [7:0]          data_o;
    logic                data_valid_o;
    logic [LEN_W-1:0]    byte_count_o;
    logic                fcs_valid_o;
    logic                fcs_ok_o;

    // header word, then the record bytes one per entry
    logic [31:0] pattern_mem [0:MEM_DEPTH-1];

    int error_count = 0;
    int cycle_count = 0;
    int cycle_limit = 0;

    rx_frame_top #(
        .HT_ENABLE(1'b1)
    ) dut_i (
        .clock(clock),
        .equalizer_reset(equalizer_reset),
        .frame_start_i(frame_start_i),
        .byte_i(byte_i),
        .byte_valid_i(byte_valid_i),
        .ht_det_valid_i(ht_det_valid_i),
        .ht_det_i(ht_det_i),
        .busy_o(busy_o),
        .header_strobe_o(header_strobe_o),
        .header_valid_o(header_valid_o),
        .pkt_ht_o(pkt_ht_o),
        .pkt_rate_o(pkt_rate_o),
        .pkt_len_o(pkt_len_o),
        .ht_sig_strobe_o(ht_sig_strobe_o),
        .ht_sig_crc_ok_o(ht_sig_crc_ok_o),
        .status_o(status_o),
        .data_o(data_o),
        .data_valid_o(data_valid_o),
        .byte_count_o(byte_count_o),
        .fcs_valid_o(fcs_valid_o),
        .fcs_ok_o(fcs_ok_o)
    );

    initial clock = 1'b0;
    always #2 clock = ~clock;

    // run budget comes from the record sizes
    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout after %0d cycles, the DUT stopped answering", cycle_count);
            $display("errors: %0d", error_count + 1);
            $display("Test failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_status(input string name, input rx_status_e expected,
                                input rx_status_e actual);
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch at %0t: %s expected %s, got %s", $time, name,
                     expected.name(), actual.name());
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch at %0t: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    task automatic check_len(input string name, input logic [LEN_W-1:0] expected,
                             input logic [LEN_W-1:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    // inputs change just after the rising edge
    task automatic wait_cycle();
        @(posedge clock);
        #0.5;
    endtask

    // one strobe, then one idle cycle
    task automatic send_byte(input logic [7:0] value);
        wait_cycle();
        byte_i = value;
        byte_valid_i = 1'b1;
        wait_cycle();
        byte_valid_i = 1'b0;
    endtask

    task automatic send_data_byte(input logic [7:0] value, input int index);
        send_byte(value);
        check_bit("data_valid_o", 1'b1, data_valid_o);
        check_byte("data_o", value, data_o);
        check_len("byte_count_o", LEN_W'(index + 1), byte_count_o);
    endtask

    function automatic bit record_present(input int ptr);
        return ptr < MEM_DEPTH && !$isunknown(pattern_mem[ptr]) && pattern_mem[ptr] != 32'h0;
    endfunction

    task automatic run_record(input int base);
        logic [31:0]       hdr;
        int                total;
        int                ht_flag;
        int                hdr_bytes;
        int                data_bytes;
        logic              exp_valid;
        logic              exp_fcs_ok;
        logic              ht_sig_seen;
        rx_status_e        exp_status;
        logic [RATE_W-1:0] exp_rate;

        hdr = pattern_mem[base];
        total = int'(hdr[31:20]);
        ht_flag = int'(hdr[19:16]);
        exp_valid = hdr[12];
        exp_fcs_ok = hdr[8];
        exp_status = rx_status_e'(hdr[4:0]);
        hdr_bytes = (ht_flag == 2) ? 9 : 3;
        data_bytes = total - hdr_bytes;

        wait_cycle();
        frame_start_i = 1'b1;
        wait_cycle();
        frame_start_i = 1'b0;

        for (int i = 0; i < 3; i++) begin
            send_byte(pattern_mem[base + 1 + i][7:0]);
        end

        // verdict arrives once the SIGNAL check is over
        if (ht_flag != 0) begin
            wait_cycle();
            wait_cycle();
            ht_det_valid_i = 1'b1;
            ht_det_i = (ht_flag == 2);
            wait_cycle();
            ht_det_valid_i = 1'b0;
            ht_det_i = 1'b0;
        end

        if (ht_flag == 2) begin
            for (int i = 3; i < 9; i++) begin
                send_byte(pattern_mem[base + 1 + i][7:0]);
            end
        end

        // HT-SIG strobe comes with or just before the header strobe
        ht_sig_seen = 1'b0;
        while (header_strobe_o !== 1'b1) begin
            wait_cycle();
            if (ht_sig_strobe_o === 1'b1) begin
                ht_sig_seen = 1'b1;
            end
        end
        check_bit("ht_sig_strobe_o", ht_flag == 2, ht_sig_seen);
        check_bit("header_valid_o", exp_valid, header_valid_o);
        check_status("status_o", exp_valid ? ok : exp_status, status_o);
        check_bit("pkt_ht_o", ht_flag == 2, pkt_ht_o);
        check_bit("ht_sig_crc_ok_o", (ht_flag == 2) && (exp_status != wrong_crc),
                  ht_sig_crc_ok_o);

        if (exp_valid) begin
            // rate is the legacy code, or the HT flag with the MCS
            if (ht_flag == 2) begin
                exp_rate = {1'b1, pattern_mem[base + 4][6:0]};
            end else begin
                exp_rate = RATE_W'(pattern_mem[base + 1][3:0]);
            end
            check_byte("pkt_rate_o", exp_rate, pkt_rate_o);
            check_len("pkt_len_o", LEN_W'(data_bytes), pkt_len_o);

            for (int i = 0; i < data_bytes; i++) begin
                send_data_byte(pattern_mem[base + 1 + hdr_bytes + i][7:0], i);
            end

            while (fcs_valid_o !== 1'b1) begin
                wait_cycle();
            end
            check_bit("fcs_ok_o", exp_fcs_ok, fcs_ok_o);
            check_status("status_o", exp_status, status_o);
        end

        // drain back to idle
        while (busy_o) begin
            wait_cycle();
            if (fcs_valid_o === 1'b1) begin
                error_count++;
                $display("at %0t fcs_valid_o pulsed where no frame check was due", $time);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int ptr;
        int records;
        int byte_total;

        equalizer_reset = 1'b1;
        frame_start_i = 1'b0;
        byte_i = 8'h00;
        byte_valid_i = 1'b0;
        ht_det_valid_i = 1'b0;
        ht_det_i = 1'b0;

        $readmemh("tests/rx_frame_patterns.hex", pattern_mem);

        ptr = 0;
        records = 0;
        byte_total = 0;
        while (record_present(ptr)) begin
            records++;
            byte_total += int'(pattern_mem[ptr][31:20]);
            ptr += int'(pattern_mem[ptr][31:20]) + 1;
        end
        cycle_limit = byte_total * 4 + records * RECORD_CYCLES;
        if (records == 0) begin
            error_count++;
            $display("no records found in the pattern file");
        end

        repeat (5) @(posedge clock);
        #0.5;
        equalizer_reset = 1'b0;

        check_bit("busy_o", 1'b0, busy_o);
        check_bit("header_strobe_o", 1'b0, header_strobe_o);
        check_bit("header_valid_o", 1'b0, header_valid_o);
        check_bit("ht_sig_strobe_o", 1'b0, ht_sig_strobe_o);
        check_bit("fcs_valid_o", 1'b0, fcs_valid_o);
        check_bit("fcs_ok_o", 1'b0, fcs_ok_o);
        check_bit("data_valid_o", 1'b0, data_valid_o);
        check_status("status_o", ok, status_o);

        ptr = 0;
        while (record_present(ptr)) begin
            run_record(ptr);
            ptr += int'(pattern_mem[ptr][31:20]) + 1;
        end

        $display("errors: %0d", error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
